// File: hdl/lbs_pkg.sv
`default_nettype none

package lbs_pkg;

  // ------------------------------
  // data widths
  // ------------------------------
  typedef logic [7:0]         pixel_t;  // camera pixel.
  typedef logic [11:0]        coord_t;  // original or resized coordinate.
  typedef logic [15:0]        integ_t;  // integral image value.
  typedef logic signed [16:0] score_t;  // rectangle sum and threshold.

  // ------------------------------
  // window geometry
  // ------------------------------
  localparam int WIN_DIM   = 3;
  localparam int WIN_CELLS = WIN_DIM * WIN_DIM;

  typedef logic [3:0] corner_t;  // cell index, row * WIN_DIM + col.

  // cell 0 is the top-left (oldest row), the last cell is the newest value.
  typedef integ_t [WIN_CELLS-1:0] win_t;

  // ------------------------------
  // bundles
  // ------------------------------

  // a pixel that survived decimation.
  typedef struct packed {
    coord_t x;
    coord_t y;
    pixel_t value;
  } rsz_pix_t;

  // resized position of the bottom-right window cell.
  typedef struct packed {
    coord_t x;
    coord_t y;
  } win_pos_t;

  // one classifier stage, score = d - b - c + a.
  typedef struct packed {
    corner_t corner_a;
    corner_t corner_b;
    corner_t corner_c;
    corner_t corner_d;
    score_t  threshold;
  } stage_param_t;

endpackage

`default_nettype wire

// File: hdl/frame_resize.sv
`default_nettype none

module frame_resize #(
  parameter int ORIG_W = 20,
  parameter int ORIG_H = 20,
  parameter int RSZ_W  = 10,
  parameter int RSZ_H  = 10
) (
  input  wire                clk_os,
  input  wire                i_rst_n,
  input  wire                i_pix_valid,
  input  wire lbs_pkg::pixel_t i_pixel,
  input  wire lbs_pkg::coord_t i_ori_x,
  input  wire lbs_pkg::coord_t i_ori_y,
  output lbs_pkg::rsz_pix_t  o_rsz_pix,
  output logic               o_reach
);

  import lbs_pkg::*;

  localparam int STEP_X = ORIG_W / RSZ_W;
  localparam int STEP_Y = ORIG_H / RSZ_H;

  localparam coord_t STEP_X_C = coord_t'(STEP_X);
  localparam coord_t STEP_Y_C = coord_t'(STEP_Y);
  localparam coord_t RSZ_W_C  = coord_t'(RSZ_W);
  localparam coord_t RSZ_H_C  = coord_t'(RSZ_H);

  logic keep;

  // pixel sits on the decimation grid.
  assign keep = i_pix_valid &&
                ((i_ori_x % STEP_X_C) == '0) &&
                ((i_ori_y % STEP_Y_C) == '0);

  always_ff @(posedge clk_os) begin
    if (!i_rst_n) begin
      o_reach <= 1'b0;
    end else begin
      o_reach <= keep;  // one pulse per kept pixel.
    end
  end

  // coordinates and value hold between kept pixels.
  always_ff @(posedge clk_os) begin
    if (keep) begin
      o_rsz_pix.x     <= i_ori_x / STEP_X_C;
      o_rsz_pix.y     <= i_ori_y / STEP_Y_C;
      o_rsz_pix.value <= i_pixel;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  a_reach_in_frame: assert property (
    @(posedge clk_os) disable iff (!i_rst_n)
    o_reach |-> (o_rsz_pix.x < RSZ_W_C) && (o_rsz_pix.y < RSZ_H_C)
  );

  // a fractional step would skew the grid across the frame.
  a_step_even: assert property (
    @(posedge clk_os)
    ((ORIG_W % RSZ_W) == 0) && ((ORIG_H % RSZ_H) == 0)
  );

endmodule

`default_nettype wire

// File: hdl/integral_window.sv
`default_nettype none

module integral_window #(
  parameter int RSZ_W = 10,
  parameter int RSZ_H = 10
) (
  input  wire                   clk_os,
  input  wire                   i_rst_n,
  input  wire                   i_reach,
  input  wire lbs_pkg::rsz_pix_t i_rsz_pix,
  output lbs_pkg::win_t         o_win,
  output lbs_pkg::win_pos_t     o_win_pos,
  output logic                  o_win_valid
);

  import lbs_pkg::*;

  localparam int AW = $clog2(RSZ_W);

  localparam coord_t RSZ_W_C  = coord_t'(RSZ_W);
  localparam coord_t RSZ_H_C  = coord_t'(RSZ_H);
  localparam coord_t WIN_EDGE = coord_t'(WIN_DIM - 1);  // first coord with a full window.

  // ------------------------------
  // line buffers and row sum
  // ------------------------------
  integ_t line_1 [RSZ_W];  // integral values of row y-1.
  integ_t line_2 [RSZ_W];  // integral values of row y-2.

  integ_t        row_sum;
  integ_t        row_sum_nxt;
  integ_t        above_1;
  integ_t        above_2;
  integ_t        integ_new;
  integ_t        col_new [WIN_DIM];
  logic [AW-1:0] col_idx;
  logic          full_win;
  coord_t        last_x;

  assign col_idx = i_rsz_pix.x[AW-1:0];

  always_comb begin
    // the row sum restarts at x = 0.
    if (i_rsz_pix.x == '0) begin
      row_sum_nxt = integ_t'(i_rsz_pix.value);
    end else begin
      row_sum_nxt = row_sum + integ_t'(i_rsz_pix.value);
    end

    // rows above the frame count as zero, so each frame starts clean.
    above_1 = (i_rsz_pix.y == '0) ? '0 : line_1[col_idx];
    above_2 = (i_rsz_pix.y < WIN_EDGE) ? '0 : line_2[col_idx];

    integ_new = row_sum_nxt + above_1;

    col_new[0] = above_2;  // oldest row.
    col_new[1] = above_1;
    col_new[2] = integ_new;
  end

  assign full_win = (i_rsz_pix.x >= WIN_EDGE) && (i_rsz_pix.x < RSZ_W_C) &&
                    (i_rsz_pix.y >= WIN_EDGE) && (i_rsz_pix.y < RSZ_H_C);

  // ------------------------------
  // datapath
  // ------------------------------
  always_ff @(posedge clk_os) begin
    if (i_reach) begin
      row_sum          <= row_sum_nxt;
      line_1[col_idx]  <= integ_new;
      line_2[col_idx]  <= above_1;

      // shift every row left, the new column enters on the right.
      for (int r = 0; r < WIN_DIM; r++) begin
        for (int c = 0; c < WIN_DIM - 1; c++) begin
          o_win[r*WIN_DIM + c] <= o_win[r*WIN_DIM + c + 1];
        end
        o_win[r*WIN_DIM + WIN_DIM - 1] <= col_new[r];
      end

      o_win_pos.x <= i_rsz_pix.x;
      o_win_pos.y <= i_rsz_pix.y;
    end
  end

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk_os) begin
    if (!i_rst_n) begin
      o_win_valid <= 1'b0;
      last_x      <= '0;
    end else begin
      o_win_valid <= i_reach && full_win;
      if (i_reach) begin
        last_x <= i_rsz_pix.x;
      end
    end
  end

  // the window shift assumes no column is skipped within a row.
  a_x_sequence: assert property (
    @(posedge clk_os) disable iff (!i_rst_n)
    i_reach |-> (i_rsz_pix.x == '0) || (i_rsz_pix.x == last_x + coord_t'(1))
  );

endmodule

`default_nettype wire

// File: hdl/cascade_stage.sv
`default_nettype none

module cascade_stage (
  input  wire                       clk_os,
  input  wire                       i_rst_n,
  input  wire                       i_valid,
  input  wire lbs_pkg::win_t        i_win,
  input  wire lbs_pkg::win_pos_t    i_pos,
  input  wire                       i_pass,
  input  wire lbs_pkg::stage_param_t i_param,
  output logic                      o_valid,
  output lbs_pkg::win_t             o_win,
  output lbs_pkg::win_pos_t         o_pos,
  output logic                      o_pass
);

  import lbs_pkg::*;

  localparam corner_t CELL_LIMIT = corner_t'(WIN_CELLS);

  score_t val_a;
  score_t val_b;
  score_t val_c;
  score_t val_d;
  score_t score;
  logic   stage_ok;

  // zero-extend the corners, then take the signed four-corner sum.
  always_comb begin
    val_a = score_t'({1'b0, i_win[i_param.corner_a]});
    val_b = score_t'({1'b0, i_win[i_param.corner_b]});
    val_c = score_t'({1'b0, i_win[i_param.corner_c]});
    val_d = score_t'({1'b0, i_win[i_param.corner_d]});
    score = val_d - val_b - val_c + val_a;
  end

  assign stage_ok = (score >= i_param.threshold);

  always_ff @(posedge clk_os) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk_os) begin
    o_win  <= i_win;
    o_pos  <= i_pos;
    o_pass <= i_pass && stage_ok;  // any failed stage sticks.
  end

  a_corner_range: assert property (
    @(posedge clk_os) disable iff (!i_rst_n)
    i_valid |-> (i_param.corner_a < CELL_LIMIT) && (i_param.corner_b < CELL_LIMIT) &&
                (i_param.corner_c < CELL_LIMIT) && (i_param.corner_d < CELL_LIMIT)
  );

endmodule

`default_nettype wire

// File: hdl/cascade_classifier.sv
`default_nettype none

module cascade_classifier #(
  parameter int NUM_STAGES = 4
) (
  input  wire                        clk_os,
  input  wire                        i_rst_n,
  input  wire                        i_win_valid,
  input  wire lbs_pkg::win_t         i_win,
  input  wire lbs_pkg::win_pos_t     i_win_pos,
  input  wire lbs_pkg::stage_param_t [NUM_STAGES-1:0] i_stage_params,
  output logic                       o_cand_valid,
  output logic                       o_candidate,
  output lbs_pkg::coord_t            o_cand_x,
  output lbs_pkg::coord_t            o_cand_y
);

  import lbs_pkg::*;

  // ------------------------------
  // stage chain
  // ------------------------------
  // entry 0 is the classifier input, entry s+1 is the output of stage s.
  logic     valid_chain [NUM_STAGES+1];
  win_t     win_chain   [NUM_STAGES+1];
  win_pos_t pos_chain   [NUM_STAGES+1];
  logic     pass_chain  [NUM_STAGES+1];

  assign valid_chain[0] = i_win_valid;
  assign win_chain[0]   = i_win;
  assign pos_chain[0]   = i_win_pos;
  assign pass_chain[0]  = 1'b1;  // no stage has rejected yet.

  for (genvar s = 0; s < NUM_STAGES; s++) begin : gen_stage
    cascade_stage u_stage (
      .clk_os  (clk_os),
      .i_rst_n (i_rst_n),
      .i_valid (valid_chain[s]),
      .i_win   (win_chain[s]),
      .i_pos   (pos_chain[s]),
      .i_pass  (pass_chain[s]),
      .i_param (i_stage_params[s]),
      .o_valid (valid_chain[s+1]),
      .o_win   (win_chain[s+1]),
      .o_pos   (pos_chain[s+1]),
      .o_pass  (pass_chain[s+1])
    );
  end

  // ------------------------------
  // decision
  // ------------------------------
  assign o_cand_valid = valid_chain[NUM_STAGES];
  assign o_candidate  = pass_chain[NUM_STAGES];  // every stage passed.
  assign o_cand_x     = pos_chain[NUM_STAGES].x;
  assign o_cand_y     = pos_chain[NUM_STAGES].y;

endmodule

`default_nettype wire

// File: hdl/i2lbs.sv
`default_nettype none

module i2lbs #(
  parameter int ORIG_W     = 20,
  parameter int ORIG_H     = 20,
  parameter int RSZ_W      = 10,
  parameter int RSZ_H      = 10,
  parameter int NUM_STAGES = 4
) (
  input  wire                        clk_os,
  input  wire                        i_rst_n,
  input  wire                        i_pix_valid,
  input  wire lbs_pkg::pixel_t       i_pixel,
  input  wire lbs_pkg::coord_t       i_ori_x,
  input  wire lbs_pkg::coord_t       i_ori_y,
  input  wire lbs_pkg::stage_param_t [NUM_STAGES-1:0] i_stage_params,
  output logic                       o_reach,
  output lbs_pkg::coord_t            o_resize_x,
  output lbs_pkg::coord_t            o_resize_y,
  output lbs_pkg::win_t              o_win,
  output logic                       o_win_valid,
  output logic                       o_cand_valid,
  output logic                       o_candidate,
  output lbs_pkg::coord_t            o_cand_x,
  output lbs_pkg::coord_t            o_cand_y
);

  import lbs_pkg::*;

  rsz_pix_t rsz_pix;
  win_pos_t win_pos;

  assign o_resize_x = rsz_pix.x;
  assign o_resize_y = rsz_pix.y;

  frame_resize #(
    .ORIG_W (ORIG_W),
    .ORIG_H (ORIG_H),
    .RSZ_W  (RSZ_W),
    .RSZ_H  (RSZ_H)
  ) u_resize (
    .clk_os      (clk_os),
    .i_rst_n     (i_rst_n),
    .i_pix_valid (i_pix_valid),
    .i_pixel     (i_pixel),
    .i_ori_x     (i_ori_x),
    .i_ori_y     (i_ori_y),
    .o_rsz_pix   (rsz_pix),
    .o_reach     (o_reach)   // write strobe into the integral stage.
  );

  integral_window #(
    .RSZ_W (RSZ_W),
    .RSZ_H (RSZ_H)
  ) u_integral (
    .clk_os      (clk_os),
    .i_rst_n     (i_rst_n),
    .i_reach     (o_reach),
    .i_rsz_pix   (rsz_pix),
    .o_win       (o_win),
    .o_win_pos   (win_pos),
    .o_win_valid (o_win_valid)
  );

  cascade_classifier #(
    .NUM_STAGES (NUM_STAGES)
  ) u_classifier (
    .clk_os         (clk_os),
    .i_rst_n        (i_rst_n),
    .i_win_valid    (o_win_valid),
    .i_win          (o_win),
    .i_win_pos      (win_pos),
    .i_stage_params (i_stage_params),
    .o_cand_valid   (o_cand_valid),
    .o_candidate    (o_candidate),
    .o_cand_x       (o_cand_x),
    .o_cand_y       (o_cand_y)
  );

endmodule

`default_nettype wire

// File: verif/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ------------------------------
// reference model
// ------------------------------
int rsz_img [RSZ_H][RSZ_W];  // resized pixels of the current frame.
int int_img [RSZ_H][RSZ_W];  // integral image of the current frame.

function automatic void clear_frame();
  for (int y = 0; y < RSZ_H; y++) begin
    for (int x = 0; x < RSZ_W; x++) begin
      rsz_img[y][x] = 0;
      int_img[y][x] = 0;
    end
  end
endfunction

// kept only on multiples of the step in both directions.
function automatic bit on_grid(input int ox, input int oy);
  return ((ox % STEP_X) == 0) && ((oy % STEP_Y) == 0);
endfunction

// row running sum plus the value one row up, zero above row 0.
function automatic void store_integral(input int rx, input int ry, input int val);
  int row_sum;
  row_sum = 0;
  rsz_img[ry][rx] = val;
  for (int i = 0; i <= rx; i++) begin
    row_sum += rsz_img[ry][i];
  end
  int_img[ry][rx] = row_sum + ((ry == 0) ? 0 : int_img[ry-1][rx]);
endfunction

// window ending at (rx, ry), row 0 is the oldest row.
function automatic win_t window_at(input int rx, input int ry);
  win_t w;
  for (int r = 0; r < WIN_DIM; r++) begin
    for (int c = 0; c < WIN_DIM; c++) begin
      w[r*WIN_DIM + c] = integ_t'(int_img[ry - WIN_DIM + 1 + r][rx - WIN_DIM + 1 + c]);
    end
  end
  return w;
endfunction

function automatic bit stage_passes(input win_t w, input stage_param_t p);
  int score;
  score = int'(w[p.corner_d]) - int'(w[p.corner_b]);
  score = score - int'(w[p.corner_c]) + int'(w[p.corner_a]);
  return score >= int'(p.threshold);  // threshold is signed.
endfunction

// candidate only when the whole chain passes.
function automatic bit cascade_decision(input win_t w, input param_set_t ps);
  bit pass;
  pass = 1'b1;
  for (int s = 0; s < NUM_STAGES; s++) begin
    pass = pass && stage_passes(w, ps[s]);
  end
  return pass;
endfunction

`endif

// File: verif/tb_i2lbs.sv
`default_nettype none

module tb_i2lbs;

  import lbs_pkg::*;

  localparam int ORIG_W      = 20;
  localparam int ORIG_H      = 20;
  localparam int RSZ_W       = 10;
  localparam int RSZ_H       = 10;
  localparam int NUM_STAGES  = 4;
  localparam int STEP_X      = ORIG_W / RSZ_W;
  localparam int STEP_Y      = ORIG_H / RSZ_H;
  localparam int HALF_PERIOD = 50;
  localparam int DRIVE_DLY   = 10;   // skew after the rising edge.
  localparam int WAIT_LIMIT  = 200;

  typedef stage_param_t [NUM_STAGES-1:0] param_set_t;
  typedef logic [143:0] report_t;

  // one expected event, due when the cycle count reaches due.
  typedef struct packed {
    int     due;
    coord_t x;
    coord_t y;
    win_t   win;
    logic   cand;
  } expect_t;

  logic       clk_os = 1'b0;
  logic       i_rst_n;
  logic       i_pix_valid;
  pixel_t     i_pixel;
  coord_t     i_ori_x;
  coord_t     i_ori_y;
  param_set_t i_stage_params;
  logic       o_reach;
  coord_t     o_resize_x;
  coord_t     o_resize_y;
  win_t       o_win;
  logic       o_win_valid;
  logic       o_cand_valid;
  logic       o_candidate;
  coord_t     o_cand_x;
  coord_t     o_cand_y;

  int      cyc = 0;
  expect_t reach_q[$];
  expect_t win_q[$];
  expect_t cand_q[$];
  logic    exp_reach = 1'b0;
  logic    exp_win_valid = 1'b0;
  logic    exp_cand_valid = 1'b0;
  expect_t exp_r = '0;
  expect_t exp_w = '0;
  expect_t exp_c = '0;

  `include "tb_ref_model.svh"

  i2lbs dut (.*);

  always #HALF_PERIOD clk_os = ~clk_os;

  always @(posedge clk_os) cyc <= cyc + 1;

  // ------------------------------
  // scoreboard
  // ------------------------------
  // events come due on the falling edge, ahead of the sampling edge.
  always @(negedge clk_os) begin
    exp_reach      = (reach_q.size() > 0) && (reach_q[0].due == cyc);
    exp_win_valid  = (win_q.size() > 0) && (win_q[0].due == cyc);
    exp_cand_valid = (cand_q.size() > 0) && (cand_q[0].due == cyc);
    if (exp_reach) begin
      exp_r = reach_q.pop_front();
    end
    if (exp_win_valid) begin
      exp_w = win_q.pop_front();
    end
    if (exp_cand_valid) begin
      exp_c = cand_q.pop_front();
    end
  end

  check_reach: assert property (@(posedge clk_os) disable iff (!i_rst_n)
    o_reach == exp_reach)
    else report_mismatch("reach strobe", report_t'(exp_reach), report_t'($sampled(o_reach)));
  check_resize_xy: assert property (@(posedge clk_os) disable iff (!i_rst_n)
    exp_reach |-> {o_resize_x, o_resize_y} == {exp_r.x, exp_r.y})
    else report_mismatch("resize xy", report_t'({exp_r.x, exp_r.y}),
                         report_t'($sampled({o_resize_x, o_resize_y})));
  check_win_valid: assert property (@(posedge clk_os) disable iff (!i_rst_n)
    o_win_valid == exp_win_valid)
    else report_mismatch("window strobe", report_t'(exp_win_valid),
                         report_t'($sampled(o_win_valid)));
  check_win: assert property (@(posedge clk_os) disable iff (!i_rst_n)
    exp_win_valid |-> o_win == exp_w.win)
    else report_mismatch("integral window", report_t'(exp_w.win), report_t'($sampled(o_win)));
  check_cand_valid: assert property (@(posedge clk_os) disable iff (!i_rst_n)
    o_cand_valid == exp_cand_valid)
    else report_mismatch("candidate strobe", report_t'(exp_cand_valid),
                         report_t'($sampled(o_cand_valid)));
  check_cand_xy: assert property (@(posedge clk_os) disable iff (!i_rst_n)
    exp_cand_valid |-> {o_cand_x, o_cand_y} == {exp_c.x, exp_c.y})
    else report_mismatch("candidate xy", report_t'({exp_c.x, exp_c.y}),
                         report_t'($sampled({o_cand_x, o_cand_y})));
  check_candidate: assert property (@(posedge clk_os) disable iff (!i_rst_n)
    exp_cand_valid |-> o_candidate == exp_c.cand)
    else report_mismatch("candidate decision", report_t'(exp_c.cand),
                         report_t'($sampled(o_candidate)));

  task automatic report_mismatch(input string test, input report_t exp_v, input report_t act_v);
    $display("Error: %s expected %0h actual %0h", test, exp_v, act_v);
    $display("TEST FAILED");
    $fatal(1, "%s mismatch", test);
  endtask

  task automatic report_stall(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic drive_cycle(input logic valid, input int ox, input int oy, input int val);
    expect_t e;
    int      rx;
    int      ry;
    @(posedge clk_os);
    #DRIVE_DLY;
    i_pix_valid = valid;
    i_ori_x     = coord_t'(ox);
    i_ori_y     = coord_t'(oy);
    i_pixel     = pixel_t'(val);
    if (valid && on_grid(ox, oy)) begin
      rx = ox / STEP_X;
      ry = oy / STEP_Y;
      store_integral(rx, ry, val);
      e     = '0;
      e.due = cyc + 1;  // reach one cycle after the pixel.
      e.x   = coord_t'(rx);
      e.y   = coord_t'(ry);
      reach_q.push_back(e);
      if ((rx >= WIN_DIM - 1) && (ry >= WIN_DIM - 1)) begin
        e.win  = window_at(rx, ry);
        e.cand = cascade_decision(e.win, i_stage_params);
        e.due  = cyc + 2;
        win_q.push_back(e);
        e.due  = cyc + 2 + NUM_STAGES;
        cand_q.push_back(e);
      end
    end
  endtask

  // frame 0 passes every stage, frame 1 can never pass stage 1.
  task automatic load_params(input int frame);
    param_set_t ps;
    for (int s = 0; s < NUM_STAGES; s++) begin
      ps[s].corner_a  = corner_t'($urandom_range(0, WIN_CELLS - 1));
      ps[s].corner_b  = corner_t'($urandom_range(0, WIN_CELLS - 1));
      ps[s].corner_c  = corner_t'($urandom_range(0, WIN_CELLS - 1));
      ps[s].corner_d  = corner_t'($urandom_range(0, WIN_CELLS - 1));
      ps[s].threshold = score_t'(int'($urandom_range(0, 4000)) - 2000);
      if (frame == 0 || frame == 1) begin
        ps[s].threshold = score_t'(-65536);
      end
      if (frame == 1 && s == 1) begin
        ps[s].threshold = score_t'(65535);
      end
    end
    @(posedge clk_os);
    #DRIVE_DLY;
    i_pix_valid    = 1'b0;
    i_stage_params = ps;
    clear_frame();
  endtask

  task automatic send_frame(input bit with_gaps);
    int gap;
    for (int oy = 0; oy < ORIG_H; oy++) begin
      for (int ox = 0; ox < ORIG_W; ox++) begin
        drive_cycle(1'b1, ox, oy, int'($urandom_range(0, 255)));
        gap = with_gaps ? int'($urandom_range(0, 2)) : 0;
        repeat (gap) begin
          drive_cycle(1'b0, 0, 0, 0);
        end
      end
    end
    drive_cycle(1'b0, 0, 0, 0);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((reach_q.size() + win_q.size() + cand_q.size()) > 0) begin
      if (waited >= WAIT_LIMIT) begin
        report_stall("Pipeline drain timed out with expected outputs still pending");
      end else begin
        @(posedge clk_os);
        waited++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'hca08));
    i_rst_n        = 1'b0;
    i_pix_valid    = 1'b0;
    i_pixel        = '0;
    i_ori_x        = '0;
    i_ori_y        = '0;
    i_stage_params = '0;
    repeat (2) @(posedge clk_os);
    #DRIVE_DLY;
    i_rst_n = 1'b1;
    repeat (4) begin
      drive_cycle(1'b0, 0, 0, 0);  // outputs stay quiet before the first pixel.
    end
    for (int f = 0; f < 4; f++) begin
      load_params(f);
      send_frame(f != 3);  // last frame runs back to back.
      wait_drain();
      repeat (2) begin
        drive_cycle(1'b0, 0, 0, 0);
      end
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+verif
hdl/lbs_pkg.sv
hdl/frame_resize.sv
hdl/integral_window.sv
hdl/cascade_stage.sv
hdl/cascade_classifier.sv
hdl/i2lbs.sv
verif/tb_i2lbs.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_i2lbs -f list.f -o tb_i2lbs \
  && ./obj_dir/tb_i2lbs > sim.log 2>&1 \
  || echo "build or simulation stopped early" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
